//--- rtl/mem_region_pkg.sv
package mem_region_pkg;

  // bus widths
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned BE_WIDTH   = 4;

  // byte offset of a word inside an address
  localparam int unsigned BYTE_OFFSET = $clog2(BE_WIDTH);

  // data ram geometry, 4096 words
  localparam int unsigned RAM_ADDR_WIDTH = 12;
  localparam int unsigned RAM_WORDS      = 1 << RAM_ADDR_WIDTH;

  // local region decode on the upper address bits
  localparam int unsigned            REGION_TAG_WIDTH = 12;
  localparam logic [REGION_TAG_WIDTH-1:0] REGION_TAG  = 12'h001;

  // responses the demux may owe at once
  localparam int unsigned LSU_MAX_OUTSTANDING = 2;
  localparam int unsigned LSU_CNT_WIDTH       = $clog2(LSU_MAX_OUTSTANDING + 1);

  typedef enum logic [0:0] {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } mem_op_e;

  // source of the next response to the load/store unit
  typedef enum logic [0:0] {
    TARGET_RAM = 1'b0,
    TARGET_EXT = 1'b1
  } mem_target_e;

  // 69 bits
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    mem_op_e               op;
    logic [BE_WIDTH-1:0]   be;
    logic [DATA_WIDTH-1:0] wdata;
  } mem_req_t;

  typedef logic [DATA_WIDTH-1:0] mem_rdata_t;

endpackage

//--- rtl/lsu_demux.sv
`timescale 1ns/1ps

module lsu_demux
  import mem_region_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  // load/store side
  input  logic       lsu_valid_i,
  output logic       lsu_ready_o,
  input  mem_req_t   lsu_req_i,
  output logic       lsu_rsp_valid_o,
  output mem_rdata_t lsu_rdata_o,

  // local data ram side
  output logic       ram_valid_o,
  input  logic       ram_ready_i,
  output mem_req_t   ram_req_o,
  input  logic       ram_rsp_valid_i,
  input  mem_rdata_t ram_rdata_i,

  // external bus side
  output logic       ext_valid_o,
  input  logic       ext_ready_i,
  output mem_req_t   ext_req_o,
  input  logic       ext_rsp_valid_i,
  input  mem_rdata_t ext_rdata_i
);

  mem_target_e              new_target;
  mem_target_e              target_q;
  logic [LSU_CNT_WIDTH-1:0] cnt_q;
  logic [LSU_CNT_WIDTH-1:0] cnt_d;
  logic                     has_room;
  logic                     order_ok;
  logic                     can_issue;
  logic                     target_ready;
  logic                     accept;

  // address decode
  assign new_target = (lsu_req_i.addr[ADDR_WIDTH-1 -: REGION_TAG_WIDTH] == REGION_TAG) ?
                      TARGET_RAM : TARGET_EXT;

  // responses must come back in order, so only one target may owe them
  assign has_room  = (cnt_q < LSU_CNT_WIDTH'(LSU_MAX_OUTSTANDING));
  assign order_ok  = (cnt_q == '0) || (new_target == target_q);
  assign can_issue = lsu_valid_i && has_room && order_ok;

  assign ram_valid_o = can_issue && (new_target == TARGET_RAM);
  assign ext_valid_o = can_issue && (new_target == TARGET_EXT);
  assign ram_req_o   = lsu_req_i;
  assign ext_req_o   = lsu_req_i;

  assign target_ready = (new_target == TARGET_RAM) ? ram_ready_i : ext_ready_i;
  assign lsu_ready_o  = lsu_valid_i && has_room && order_ok && target_ready;
  assign accept       = lsu_ready_o;

  // response select from the recorded target
  always_comb
  begin
    if (target_q == TARGET_RAM)
    begin
      lsu_rsp_valid_o = ram_rsp_valid_i;
      lsu_rdata_o     = ram_rdata_i;
    end
    else
    begin
      lsu_rsp_valid_o = ext_rsp_valid_i;
      lsu_rdata_o     = ext_rdata_i;
    end
  end

  always_comb
  begin
    cnt_d = cnt_q;
    case ({accept, lsu_rsp_valid_o})
      2'b10:   cnt_d = cnt_q + LSU_CNT_WIDTH'(1);
      2'b01:   cnt_d = cnt_q - LSU_CNT_WIDTH'(1);
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt_q    <= '0;
      target_q <= TARGET_RAM;
    end
    else
    begin
      cnt_q <= cnt_d;
      if (accept)
      begin
        target_q <= new_target;
      end
    end
  end

  // the other source stays quiet while this one owes responses
  assert property (@(posedge clk) disable iff (!rst_n)
    (cnt_q != '0) |->
      !((target_q == TARGET_RAM) ? ext_rsp_valid_i : ram_rsp_valid_i))
    else $error("response from target not recorded as owing one");

  assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= LSU_CNT_WIDTH'(LSU_MAX_OUTSTANDING))
    else $error("outstanding count above limit");

  // a response needs a request in flight
  assert property (@(posedge clk) disable iff (!rst_n)
    lsu_rsp_valid_o |-> (cnt_q != '0))
    else $error("response with nothing outstanding");

endmodule

//--- rtl/ram_port_arbiter.sv
`timescale 1ns/1ps

module ram_port_arbiter
  import mem_region_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,

  // slave side is always served first
  input  logic                      slv_valid_i,
  output logic                      slv_ready_o,
  input  mem_req_t                  slv_req_i,
  output logic                      slv_rsp_valid_o,
  output mem_rdata_t                slv_rdata_o,

  // core side
  input  logic                      core_valid_i,
  output logic                      core_ready_o,
  input  mem_req_t                  core_req_i,
  output logic                      core_rsp_valid_o,
  output mem_rdata_t                core_rdata_o,

  // single-port ram
  output logic                      ram_en_o,
  output logic [RAM_ADDR_WIDTH-1:0] ram_index_o,
  output mem_op_e                   ram_op_o,
  output logic [BE_WIDTH-1:0]       ram_be_o,
  output logic [DATA_WIDTH-1:0]     ram_wdata_o,
  input  mem_rdata_t                ram_rdata_i
);

  mem_req_t sel_req;
  logic     slv_gnt;
  logic     core_gnt;
  logic     slv_gnt_q;
  logic     core_gnt_q;

  // slave port never waits
  assign slv_ready_o  = 1'b1;
  assign core_ready_o = !slv_valid_i;

  assign slv_gnt  = slv_valid_i;
  assign core_gnt = core_valid_i && !slv_valid_i;

  assign sel_req = slv_gnt ? slv_req_i : core_req_i;

  assign ram_en_o    = slv_gnt || core_gnt;
  assign ram_index_o = sel_req.addr[BYTE_OFFSET +: RAM_ADDR_WIDTH];
  assign ram_op_o    = sel_req.op;
  assign ram_be_o    = sel_req.be;
  assign ram_wdata_o = sel_req.wdata;

  // remember who owns the ram output next cycle
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      slv_gnt_q  <= 1'b0;
      core_gnt_q <= 1'b0;
    end
    else
    begin
      slv_gnt_q  <= slv_gnt;
      core_gnt_q <= core_gnt;
    end
  end

  assign slv_rsp_valid_o  = slv_gnt_q;
  assign core_rsp_valid_o = core_gnt_q;

  always_comb
  begin
    slv_rdata_o  = '0;
    core_rdata_o = '0;
    if (slv_gnt_q)
    begin
      slv_rdata_o = ram_rdata_i;
    end
    if (core_gnt_q)
    begin
      core_rdata_o = ram_rdata_i;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    !(slv_rsp_valid_o && core_rsp_valid_o))
    else $error("both ram ports answered in one cycle");

endmodule

//--- rtl/sp_sram.sv
`timescale 1ns/1ps

module sp_sram
  import mem_region_pkg::*;
(
  input  logic                      clk,
  input  logic                      en_i,
  input  logic [RAM_ADDR_WIDTH-1:0] index_i,
  input  mem_op_e                   op_i,
  input  logic [BE_WIDTH-1:0]       be_i,
  input  logic [DATA_WIDTH-1:0]     wdata_i,
  output mem_rdata_t                rdata_o
);

  logic [DATA_WIDTH-1:0] mem [0:RAM_WORDS-1];

  // write per byte lane
  always_ff @(posedge clk)
  begin
    if (en_i && (op_i == OP_WRITE))
    begin
      for (int i = 0; i < BE_WIDTH; i++)
      begin
        if (be_i[i])
        begin
          mem[index_i][8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
    end
  end

  // registered read, data valid the cycle after en_i
  always_ff @(posedge clk)
  begin
    if (en_i && (op_i == OP_READ))
    begin
      rdata_o <= mem[index_i];
    end
  end

endmodule

//--- rtl/core_mem_region.sv
`timescale 1ns/1ps

module core_mem_region
  import mem_region_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  // load/store unit
  input  logic       lsu_valid_i,
  output logic       lsu_ready_o,
  input  mem_req_t   lsu_req_i,
  output logic       lsu_rsp_valid_o,
  output mem_rdata_t lsu_rdata_o,

  // external bus master
  output logic       ext_valid_o,
  input  logic       ext_ready_i,
  output mem_req_t   ext_req_o,
  input  logic       ext_rsp_valid_i,
  input  mem_rdata_t ext_rdata_i,

  // slave port into the data ram
  input  logic       slv_valid_i,
  output logic       slv_ready_o,
  input  mem_req_t   slv_req_i,
  output logic       slv_rsp_valid_o,
  output mem_rdata_t slv_rdata_o
);

  // demux to arbiter core port
  logic                      core_valid;
  logic                      core_ready;
  mem_req_t                  core_req;
  logic                      core_rsp_valid;
  mem_rdata_t                core_rdata;

  // arbiter to ram
  logic                      ram_en;
  logic [RAM_ADDR_WIDTH-1:0] ram_index;
  mem_op_e                   ram_op;
  logic [BE_WIDTH-1:0]       ram_be;
  logic [DATA_WIDTH-1:0]     ram_wdata;
  mem_rdata_t                ram_rdata;

  lsu_demux lsu_demux_i (
    .clk             ( clk             ),
    .rst_n           ( rst_n           ),
    .lsu_valid_i     ( lsu_valid_i     ),
    .lsu_ready_o     ( lsu_ready_o     ),
    .lsu_req_i       ( lsu_req_i       ),
    .lsu_rsp_valid_o ( lsu_rsp_valid_o ),
    .lsu_rdata_o     ( lsu_rdata_o     ),
    .ram_valid_o     ( core_valid      ),
    .ram_ready_i     ( core_ready      ),
    .ram_req_o       ( core_req        ),
    .ram_rsp_valid_i ( core_rsp_valid  ),
    .ram_rdata_i     ( core_rdata      ),
    .ext_valid_o     ( ext_valid_o     ),
    .ext_ready_i     ( ext_ready_i     ),
    .ext_req_o       ( ext_req_o       ),
    .ext_rsp_valid_i ( ext_rsp_valid_i ),
    .ext_rdata_i     ( ext_rdata_i     )
  );

  ram_port_arbiter data_ram_arb_i (
    .clk              ( clk             ),
    .rst_n            ( rst_n           ),
    .slv_valid_i      ( slv_valid_i     ),
    .slv_ready_o      ( slv_ready_o     ),
    .slv_req_i        ( slv_req_i       ),
    .slv_rsp_valid_o  ( slv_rsp_valid_o ),
    .slv_rdata_o      ( slv_rdata_o     ),
    .core_valid_i     ( core_valid      ),
    .core_ready_o     ( core_ready      ),
    .core_req_i       ( core_req        ),
    .core_rsp_valid_o ( core_rsp_valid  ),
    .core_rdata_o     ( core_rdata      ),
    .ram_en_o         ( ram_en          ),
    .ram_index_o      ( ram_index       ),
    .ram_op_o         ( ram_op          ),
    .ram_be_o         ( ram_be          ),
    .ram_wdata_o      ( ram_wdata       ),
    .ram_rdata_i      ( ram_rdata       )
  );

  sp_sram data_mem_i (
    .clk     ( clk       ),
    .en_i    ( ram_en    ),
    .index_i ( ram_index ),
    .op_i    ( ram_op    ),
    .be_i    ( ram_be    ),
    .wdata_i ( ram_wdata ),
    .rdata_o ( ram_rdata )
  );

endmodule

//--- bench/ext_bus_model.sv
`timescale 1ns/1ps

module ext_bus_model
  import mem_region_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       valid_i,
  output logic       ready_o,
  input  mem_req_t   req_i,
  output logic       rsp_valid_o,
  output mem_rdata_t rdata_o
);

  localparam int LATENCY = 3;

  logic [1:0]         phase;
  logic [LATENCY-1:0] pipe_valid;
  mem_rdata_t         pipe_data [LATENCY];
  mem_req_t           accepted_q [$];

  // ready drops on every third cycle
  assign ready_o = (phase != 2'd2);

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase      <= 2'd0;
      pipe_valid <= '0;
    end
    else
    begin
      phase      <= (phase == 2'd2) ? 2'd0 : phase + 2'd1;
      pipe_valid <= {pipe_valid[LATENCY-2:0], valid_i && ready_o};
      // read data rule of the external memory
      pipe_data[0] <= (req_i.op == OP_READ) ? (req_i.addr ^ 32'hA5A5_0000) : 32'h0;
      for (int i = 1; i < LATENCY; i++)
      begin
        pipe_data[i] <= pipe_data[i-1];
      end
      if (valid_i && ready_o)
      begin
        accepted_q.push_back(req_i);
      end
    end
  end

  assign rsp_valid_o = pipe_valid[LATENCY-1];
  assign rdata_o     = pipe_data[LATENCY-1];

endmodule

//--- bench/tb_core_mem_region.sv
`timescale 1ns/1ps

module tb_core_mem_region
  import mem_region_pkg::*;
();

  localparam int NUM_ENTRIES     = 18;
  localparam int WATCHDOG_CYCLES = NUM_ENTRIES * 200;

  typedef struct packed {
    logic [3:0]  test;
    logic        slv;
    logic        pair;
    logic        sync;
    mem_op_e     op;
    logic [31:0] addr;
    logic [3:0]  be;
    logic [31:0] wdata;
    logic [31:0] exp_rdata;
  } entry_t;

  // what a response must carry
  typedef struct packed {
    logic [31:0] rdata;
    logic        is_read;
    logic        one_cycle;
    logic [31:0] acc_cyc;
  } pending_t;

  logic        clk;
  logic        rst_n;
  logic        lsu_valid;
  logic        lsu_ready;
  mem_req_t    lsu_req;
  logic        lsu_rsp_valid;
  mem_rdata_t  lsu_rdata;
  logic        ext_valid;
  logic        ext_ready;
  mem_req_t    ext_req;
  logic        ext_rsp_valid;
  mem_rdata_t  ext_rdata;
  logic        slv_valid;
  logic        slv_ready;
  mem_req_t    slv_req;
  logic        slv_rsp_valid;
  mem_rdata_t  slv_rdata;

  entry_t      tbl [NUM_ENTRIES];
  logic [31:0] ref_ram [RAM_WORDS];
  logic [31:0] lcg_state = 32'h8832ac40;
  pending_t    lsu_pend_q [$];
  pending_t    slv_pend_q [$];
  pending_t    lsu_next;
  pending_t    slv_next;
  mem_req_t    ext_sent_q [$];
  int unsigned cyc = 0;
  int unsigned lsu_acc_cyc = 0;
  int unsigned slv_acc_cyc = 0;
  int          n_built = 0;
  int          ext_seen = 0;
  int          ram_req_cnt = 0;
  int          ram_rsp_cnt = 0;
  int          main_errs = 0;
  int          mon_errs = 0;
  int          errs_at_start = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;

  core_mem_region dut0 (
    .clk             ( clk           ),
    .rst_n           ( rst_n         ),
    .lsu_valid_i     ( lsu_valid     ),
    .lsu_ready_o     ( lsu_ready     ),
    .lsu_req_i       ( lsu_req       ),
    .lsu_rsp_valid_o ( lsu_rsp_valid ),
    .lsu_rdata_o     ( lsu_rdata     ),
    .ext_valid_o     ( ext_valid     ),
    .ext_ready_i     ( ext_ready     ),
    .ext_req_o       ( ext_req       ),
    .ext_rsp_valid_i ( ext_rsp_valid ),
    .ext_rdata_i     ( ext_rdata     ),
    .slv_valid_i     ( slv_valid     ),
    .slv_ready_o     ( slv_ready     ),
    .slv_req_i       ( slv_req       ),
    .slv_rsp_valid_o ( slv_rsp_valid ),
    .slv_rdata_o     ( slv_rdata     )
  );

  ext_bus_model ext_model0 (
    .clk         ( clk           ),
    .rst_n       ( rst_n         ),
    .valid_i     ( ext_valid     ),
    .ready_o     ( ext_ready     ),
    .req_i       ( ext_req       ),
    .rsp_valid_o ( ext_rsp_valid ),
    .rdata_o     ( ext_rdata     )
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic is_local(input logic [31:0] addr);
    return addr[31:20] == REGION_TAG;
  endfunction

  // expected data follows a word model of the ram
  function automatic void add_entry(input logic [3:0] test, input logic slv, input logic pair,
                                    input logic sync, input mem_op_e op,
                                    input logic [31:0] addr, input logic [3:0] be);
    entry_t e;
    int     idx;
    e = '0;
    e.test  = test;
    e.slv   = slv;
    e.pair  = pair;
    e.sync  = sync;
    e.op    = op;
    e.addr  = addr;
    e.be    = be;
    e.wdata = lcg_next();
    idx = int'((addr >> 2) % RAM_WORDS);
    if (!is_local(addr))
    begin
      e.exp_rdata = addr ^ 32'hA5A5_0000;
    end
    else if (op == OP_WRITE)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (be[b])
        begin
          ref_ram[idx][8*b +: 8] = e.wdata[8*b +: 8];
        end
      end
    end
    else
    begin
      e.exp_rdata = ref_ram[idx];
    end
    tbl[n_built] = e;
    n_built++;
  endfunction

  function automatic void build_table();
    add_entry(4'd2, 1'b0, 1'b0, 1'b1, OP_WRITE, 32'h0010_0010, 4'hF);
    add_entry(4'd2, 1'b0, 1'b0, 1'b1, OP_WRITE, 32'h0010_0010, 4'h5);
    add_entry(4'd2, 1'b0, 1'b0, 1'b1, OP_READ,  32'h0010_0010, 4'hF);
    add_entry(4'd3, 1'b0, 1'b0, 1'b1, OP_READ,  32'h2000_0040, 4'hF);
    add_entry(4'd3, 1'b0, 1'b0, 1'b1, OP_WRITE, 32'h2000_0044, 4'h3);
    add_entry(4'd4, 1'b1, 1'b0, 1'b1, OP_WRITE, 32'h0010_0100, 4'hF);
    add_entry(4'd4, 1'b0, 1'b0, 1'b1, OP_READ,  32'h0010_0100, 4'hF);
    add_entry(4'd4, 1'b0, 1'b0, 1'b1, OP_WRITE, 32'h0010_0104, 4'hF);
    add_entry(4'd4, 1'b1, 1'b0, 1'b1, OP_READ,  32'h0010_0104, 4'hF);
    // slave and load/store in the same cycle
    add_entry(4'd5, 1'b1, 1'b1, 1'b0, OP_WRITE, 32'h0010_0200, 4'hF);
    add_entry(4'd5, 1'b0, 1'b0, 1'b1, OP_WRITE, 32'h0010_0204, 4'hF);
    add_entry(4'd5, 1'b1, 1'b1, 1'b0, OP_READ,  32'h0010_0204, 4'hF);
    add_entry(4'd5, 1'b0, 1'b0, 1'b1, OP_READ,  32'h0010_0200, 4'hF);
    // back to back, alternating targets
    add_entry(4'd6, 1'b0, 1'b0, 1'b0, OP_READ,  32'h0010_0010, 4'hF);
    add_entry(4'd6, 1'b0, 1'b0, 1'b0, OP_READ,  32'h3000_0100, 4'hF);
    add_entry(4'd6, 1'b0, 1'b0, 1'b0, OP_WRITE, 32'h0010_0300, 4'hF);
    add_entry(4'd6, 1'b0, 1'b0, 1'b0, OP_READ,  32'h3000_0104, 4'hF);
    add_entry(4'd6, 1'b0, 1'b0, 1'b1, OP_READ,  32'h0010_0300, 4'hF);
  endfunction

  // starts 2 ns after a rising edge, returns at the same point after acceptance
  task automatic issue_lsu(input entry_t e);
    lsu_req  = '{addr: e.addr, op: e.op, be: e.be, wdata: e.wdata};
    lsu_next = '{rdata: e.exp_rdata, is_read: (e.op == OP_READ),
                 one_cycle: is_local(e.addr), acc_cyc: 32'd0};
    lsu_valid = 1'b1;
    if (is_local(e.addr))
      ram_req_cnt++;
    else
      ext_sent_q.push_back(lsu_req);
    do @(negedge clk); while (!lsu_ready);
    @(posedge clk);
    #2;
    lsu_valid = 1'b0;
  endtask

  task automatic issue_slv(input entry_t e);
    slv_req  = '{addr: e.addr, op: e.op, be: e.be, wdata: e.wdata};
    slv_next = '{rdata: e.exp_rdata, is_read: (e.op == OP_READ),
                 one_cycle: 1'b1, acc_cyc: 32'd0};
    slv_valid = 1'b1;
    do @(negedge clk); while (!slv_ready);
    @(posedge clk);
    #2;
    slv_valid = 1'b0;
  endtask

  task automatic check_response(input string name, input pending_t p, input logic [31:0] rdata);
    if (p.is_read && rdata !== p.rdata)
    begin
      $display("Fail %s: got %h expected %h", name, rdata, p.rdata);
      mon_errs++;
    end
    if (p.one_cycle && cyc != p.acc_cyc + 32'd1)
    begin
      $display("%s response came %0d cycles after acceptance, not 1", name, cyc - p.acc_cyc);
      mon_errs++;
    end
  endtask

  // sampled mid-cycle where all signals are settled
  always @(negedge clk)
  begin
    pending_t p;
    if (rst_n)
    begin
      if (lsu_rsp_valid)
      begin
        if (lsu_pend_q.size() == 0)
        begin
          $display("load/store response with no request pending");
          mon_errs++;
        end
        else
          check_response("lsu_rdata_o", lsu_pend_q.pop_front(), lsu_rdata);
      end
      if (slv_rsp_valid)
      begin
        if (slv_pend_q.size() == 0)
        begin
          $display("slave port response with no request pending");
          mon_errs++;
        end
        else
          check_response("slv_rdata_o", slv_pend_q.pop_front(), slv_rdata);
      end
      if (dut0.core_rsp_valid)
        ram_rsp_cnt++;
      if (lsu_valid && lsu_ready)
      begin
        p = lsu_next;
        p.one_cycle = lsu_next.one_cycle && !slv_valid;
        p.acc_cyc = cyc;
        lsu_pend_q.push_back(p);
        lsu_acc_cyc = cyc;
      end
      if (slv_valid && slv_ready)
      begin
        p = slv_next;
        p.acc_cyc = cyc;
        slv_pend_q.push_back(p);
        slv_acc_cyc = cyc;
      end
    end
  end

  task automatic wait_idle();
    mem_req_t want;
    mem_req_t got;
    while (lsu_pend_q.size() != 0 || slv_pend_q.size() != 0)
      @(posedge clk);
    repeat (2) @(posedge clk);
    #2;
    if (ram_rsp_cnt != ram_req_cnt)
    begin
      $display("%0d ram responses for %0d local load/store requests", ram_rsp_cnt, ram_req_cnt);
      main_errs++;
      ram_rsp_cnt = ram_req_cnt;
    end
    while (ext_sent_q.size() != 0)
    begin
      want = ext_sent_q.pop_front();
      if (ext_seen >= ext_model0.accepted_q.size())
      begin
        $display("external request to %h never reached the bus", want.addr);
        main_errs++;
      end
      else
      begin
        got = ext_model0.accepted_q[ext_seen];
        ext_seen++;
        if (got !== want)
        begin
          $display("Fail ext_req_o: got %h expected %h", got, want);
          main_errs++;
        end
      end
    end
    if (ext_model0.accepted_q.size() != ext_seen)
    begin
      $display("external bus took requests that were not sent to it");
      main_errs++;
      ext_seen = ext_model0.accepted_q.size();
    end
  endtask

  task automatic finish_test(input logic [3:0] test);
    int errs;
    errs = main_errs + mon_errs - errs_at_start;
    if (errs == 0)
    begin
      $display("test %0d passed", test);
      tests_passed++;
    end
    else
    begin
      $display("test %0d failed with %0d errors", test, errs);
      tests_failed++;
    end
    errs_at_start = main_errs + mon_errs;
  endtask

  initial
  begin
    int i;
    rst_n     = 1'b0;
    lsu_valid = 1'b0;
    lsu_req   = '0;
    slv_valid = 1'b0;
    slv_req   = '0;
    lsu_next  = '0;
    slv_next  = '0;
    build_table();
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    if (lsu_rsp_valid !== 1'b0 || slv_rsp_valid !== 1'b0 || ext_valid !== 1'b0)
    begin
      $display("Fail lsu_rsp_valid_o %h slv_rsp_valid_o %h ext_valid_o %h expected 0",
               lsu_rsp_valid, slv_rsp_valid, ext_valid);
      main_errs++;
    end
    finish_test(4'd1);
    @(posedge clk);
    #2;
    i = 0;
    while (i < NUM_ENTRIES)
    begin
      if (tbl[i].pair)
      begin
        fork
          issue_slv(tbl[i]);
          issue_lsu(tbl[i+1]);
        join
        if (slv_acc_cyc >= lsu_acc_cyc)
        begin
          $display("slave port was not served before the load/store port");
          main_errs++;
        end
        i++;
      end
      else if (tbl[i].slv)
        issue_slv(tbl[i]);
      else
        issue_lsu(tbl[i]);
      if (tbl[i].sync)
        wait_idle();
      if (i == NUM_ENTRIES - 1 || tbl[i+1].test != tbl[i].test)
        finish_test(tbl[i].test);
      i++;
    end
    $display("%0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, main_errs + mon_errs);
    if (tests_failed == 0 && main_errs + mon_errs == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
    $display("Testbench failed");
    $finish;
  end

endmodule

//--- all.f
rtl/mem_region_pkg.sv
rtl/lsu_demux.sv
rtl/ram_port_arbiter.sv
rtl/sp_sram.sv
rtl/core_mem_region.sv
bench/ext_bus_model.sv
bench/tb_core_mem_region.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_core_mem_region
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "Testbench passed" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
